/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and address width
`define CPU_WORD_WIDTH 32

// Architectural registers
`define CPU_REG_COUNT 32

// Program store size in words
`define CPU_IMEM_DEPTH 256

// Byte address of the first instruction
`define CPU_START_ADDR 32'h8002_0000

`endif

/* design/isa_pkg.sv */
`include "cpu_settings.svh"

package isa_pkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;

	// Major opcodes, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_addi  = 6'b001000,
		op_addiu = 6'b001001,
		op_slti  = 6'b001010,
		op_sltiu = 6'b001011,
		op_ori   = 6'b001101,
		op_xori  = 6'b001110,
		op_lui   = 6'b001111
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fn_sll  = 6'b000000,  // Also NOP
		fn_srl  = 6'b000010,
		fn_sra  = 6'b000011,
		fn_sllv = 6'b000100,
		fn_srlv = 6'b000110,
		fn_srav = 6'b000111,
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_nor  = 6'b100111,
		fn_slt  = 6'b101010,
		fn_sltu = 6'b101011
	} func_e;

endpackage

/* design/pipe_pkg.sv */
`include "cpu_settings.svh"

package pipe_pkg;

	typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_idx_t;
	typedef logic [$clog2(`CPU_IMEM_DEPTH):0] imem_count_t;  // Holds 0 up to full depth

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui, alu_none
	} alu_op_e;

	typedef enum logic [1:0] {idle, running, drained} fetch_state_e;

	typedef struct packed {
		imem_idx_t index;
		isa_pkg::word_t instr;
	} load_pkt_t;

	typedef struct packed {
		isa_pkg::word_t pc;
		isa_pkg::word_t instr;
	} fetch_pkt_t;

	typedef struct packed {
		isa_pkg::word_t pc;
		isa_pkg::word_t instr;
		alu_op_e op;
		isa_pkg::word_t a;  // rs or shift amount
		isa_pkg::word_t b;  // rt or immediate
		isa_pkg::reg_idx_t dest;
		logic wr;
	} decode_pkt_t;

	typedef struct packed {
		isa_pkg::word_t pc;
		isa_pkg::word_t instr;
		isa_pkg::reg_idx_t dest;
		isa_pkg::word_t result;
		logic wr;
	} retire_pkt_t;

endpackage

/* design/instr_memory.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module instr_memory (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   load_valid,
	input  pipe_pkg::load_pkt_t    load,
	input  logic                   rd_en,
	input  pipe_pkg::imem_idx_t    rd_index,
	output isa_pkg::word_t         rd_data,
	output pipe_pkg::imem_count_t  loaded_count
);

	isa_pkg::word_t mem [`CPU_IMEM_DEPTH];
	pipe_pkg::imem_count_t load_end;

	assign load_end = pipe_pkg::imem_count_t'(load.index) + 1'b1;

	always_ff @(posedge clock) begin
		if (load_valid)
			mem[load.index] <= load.instr;
		if (rd_en)
			rd_data <= mem[rd_index];  // Held until the next read
	end

	// Program end is one past the highest index written
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			loaded_count <= '0;
		end else if (load_valid && load_end > loaded_count) begin
			loaded_count <= load_end;
		end
	end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module fetch_stage (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   start,
	input  pipe_pkg::imem_count_t  loaded_count,
	output logic                   load_ready,
	output logic                   rd_en,
	output pipe_pkg::imem_idx_t    rd_index,
	input  isa_pkg::word_t         rd_data,
	output logic                   fetch_valid,
	input  logic                   fetch_ready,
	output pipe_pkg::fetch_pkt_t   fetch,
	output logic                   fetching_done
);

	pipe_pkg::fetch_state_e state;
	pipe_pkg::imem_count_t idx;
	isa_pkg::word_t next_pc;
	isa_pkg::word_t out_pc;
	logic has_word;

	assign load_ready = (state == pipe_pkg::idle);
	assign fetching_done = (state == pipe_pkg::drained);
	assign rd_index = pipe_pkg::imem_idx_t'(idx);
	// Read only when the slot is empty or emptying this cycle
	assign rd_en = (state == pipe_pkg::running) && (idx < loaded_count) &&
		(!has_word || fetch_ready);

	assign fetch_valid = has_word;
	assign fetch = '{pc: out_pc, instr: rd_data};  // Memory output holds the word

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= pipe_pkg::idle;
			idx <= '0;
			next_pc <= `CPU_START_ADDR;
			out_pc <= '0;
			has_word <= 1'b0;
		end else begin
			if (state == pipe_pkg::idle && start)
				state <= pipe_pkg::running;
			else if (state == pipe_pkg::running && idx == loaded_count)
				state <= pipe_pkg::drained;

			if (rd_en) begin
				idx <= idx + 1'b1;
				next_pc <= next_pc + 32'd4;
				out_pc <= next_pc;
				has_word <= 1'b1;
			end else if (fetch_ready) begin
				has_word <= 1'b0;
			end
		end
	end

endmodule

/* design/register_file.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module register_file (
	input  logic               clock,
	input  logic               rst_n,
	input  isa_pkg::reg_idx_t  rs_idx,
	input  isa_pkg::reg_idx_t  rt_idx,
	output isa_pkg::word_t     rs_val,
	output isa_pkg::word_t     rt_val,
	input  logic               wr_en,
	input  isa_pkg::reg_idx_t  wr_idx,
	input  isa_pkg::word_t     wr_val
);

	isa_pkg::word_t regs [`CPU_REG_COUNT];

	// Write-through so a same-cycle reader sees the new value
	function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (wr_en && wr_idx == idx)
			return wr_val;
		else
			return regs[idx];
	endfunction

	assign rs_val = read_port(rs_idx);
	assign rt_val = read_port(rt_idx);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_val;
		end
	end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module decode_stage (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    fetch_valid,
	output logic                    fetch_ready,
	input  pipe_pkg::fetch_pkt_t    fetch,
	output isa_pkg::reg_idx_t       rs_idx,
	output isa_pkg::reg_idx_t       rt_idx,
	input  isa_pkg::word_t          rs_val,
	input  isa_pkg::word_t          rt_val,
	output logic                    dec_valid,
	input  logic                    dec_ready,
	output pipe_pkg::decode_pkt_t   dec
);

	pipe_pkg::fetch_pkt_t held;
	isa_pkg::opcode_e opcode;
	isa_pkg::func_e funct;
	isa_pkg::shamt_t shamt;
	isa_pkg::imm16_t imm;
	isa_pkg::reg_idx_t rd_idx;
	isa_pkg::word_t imm_sx;
	isa_pkg::word_t imm_zx;
	isa_pkg::word_t imm_ext;
	pipe_pkg::alu_op_e op;
	isa_pkg::reg_idx_t dest;
	logic use_shamt;
	logic use_imm;
	logic wr;

	assign opcode = isa_pkg::opcode_e'(held.instr[31:26]);
	assign rs_idx = held.instr[25:21];
	assign rt_idx = held.instr[20:16];
	assign rd_idx = held.instr[15:11];
	assign shamt = held.instr[10:6];
	assign funct = isa_pkg::func_e'(held.instr[5:0]);
	assign imm = held.instr[15:0];
	assign imm_sx = {{(`CPU_WORD_WIDTH-16){imm[15]}}, imm};
	assign imm_zx = {{(`CPU_WORD_WIDTH-16){1'b0}}, imm};

	always_comb begin
		op = pipe_pkg::alu_none;
		use_shamt = 1'b0;
		use_imm = 1'b1;
		imm_ext = imm_sx;
		dest = rt_idx;  // I-type default
		wr = 1'b1;
		case (opcode)
			isa_pkg::op_rtype: begin
				use_imm = 1'b0;
				dest = rd_idx;
				case (funct)
					isa_pkg::fn_add, isa_pkg::fn_addu: op = pipe_pkg::alu_add;
					isa_pkg::fn_sub, isa_pkg::fn_subu: op = pipe_pkg::alu_sub;
					isa_pkg::fn_and:  op = pipe_pkg::alu_and;
					isa_pkg::fn_or:   op = pipe_pkg::alu_or;
					isa_pkg::fn_xor:  op = pipe_pkg::alu_xor;
					isa_pkg::fn_nor:  op = pipe_pkg::alu_nor;
					isa_pkg::fn_slt:  op = pipe_pkg::alu_slt;
					isa_pkg::fn_sltu: op = pipe_pkg::alu_sltu;
					isa_pkg::fn_sll: begin
						op = pipe_pkg::alu_sll;
						use_shamt = 1'b1;
					end
					isa_pkg::fn_srl: begin
						op = pipe_pkg::alu_srl;
						use_shamt = 1'b1;
					end
					isa_pkg::fn_sra: begin
						op = pipe_pkg::alu_sra;
						use_shamt = 1'b1;
					end
					isa_pkg::fn_sllv: op = pipe_pkg::alu_sll;
					isa_pkg::fn_srlv: op = pipe_pkg::alu_srl;
					isa_pkg::fn_srav: op = pipe_pkg::alu_sra;
					default: wr = 1'b0;
				endcase
			end
			isa_pkg::op_addi, isa_pkg::op_addiu: op = pipe_pkg::alu_add;
			isa_pkg::op_slti:  op = pipe_pkg::alu_slt;
			isa_pkg::op_sltiu: op = pipe_pkg::alu_sltu;  // Still sign extended
			isa_pkg::op_ori: begin
				op = pipe_pkg::alu_or;
				imm_ext = imm_zx;
			end
			isa_pkg::op_xori: begin
				op = pipe_pkg::alu_xor;
				imm_ext = imm_zx;
			end
			isa_pkg::op_lui: begin
				op = pipe_pkg::alu_lui;
				imm_ext = {imm, 16'b0};
			end
			default: wr = 1'b0;
		endcase
	end

	// Operands sampled as the record moves to execute
	assign dec = '{
		pc: held.pc,
		instr: held.instr,
		op: op,
		a: use_shamt ? isa_pkg::word_t'(shamt) : rs_val,
		b: use_imm ? imm_ext : rt_val,
		dest: dest,
		wr: wr
	};

	assign fetch_ready = !dec_valid || dec_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (fetch_valid && fetch_ready)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && fetch_ready)
			held <= fetch;
	end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    dec_valid,
	output logic                    dec_ready,
	input  pipe_pkg::decode_pkt_t   dec,
	output logic                    retire_valid,
	input  logic                    retire_ready,
	output pipe_pkg::retire_pkt_t   retire,
	output logic                    wr_en,
	output isa_pkg::reg_idx_t       wr_idx,
	output isa_pkg::word_t          wr_val
);

	isa_pkg::shamt_t sh;
	isa_pkg::word_t result;

	assign sh = dec.a[4:0];  // Low five bits only

	always_comb begin
		case (dec.op)
			pipe_pkg::alu_add:  result = dec.a + dec.b;
			pipe_pkg::alu_sub:  result = dec.a - dec.b;
			pipe_pkg::alu_and:  result = dec.a & dec.b;
			pipe_pkg::alu_or:   result = dec.a | dec.b;
			pipe_pkg::alu_xor:  result = dec.a ^ dec.b;
			pipe_pkg::alu_nor:  result = ~(dec.a | dec.b);
			pipe_pkg::alu_slt:  result = isa_pkg::word_t'($signed(dec.a) < $signed(dec.b));
			pipe_pkg::alu_sltu: result = isa_pkg::word_t'(dec.a < dec.b);
			pipe_pkg::alu_sll:  result = dec.b << sh;
			pipe_pkg::alu_srl:  result = dec.b >> sh;
			pipe_pkg::alu_sra:  result = $signed(dec.b) >>> sh;
			pipe_pkg::alu_lui:  result = dec.b;  // Already shifted up in decode
			default:            result = '0;
		endcase
	end

	assign dec_ready = !retire_valid || retire_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			retire_valid <= 1'b0;
		else if (dec_valid && dec_ready)
			retire_valid <= 1'b1;
		else if (retire_ready)
			retire_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (dec_valid && dec_ready)
			retire <= '{pc: dec.pc, instr: dec.instr, dest: dec.dest, result: result, wr: dec.wr};
	end

	// Write back on the retire handshake
	assign wr_en = retire_valid && retire_ready && retire.wr;
	assign wr_idx = retire.dest;
	assign wr_val = retire.result;

endmodule

/* design/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   load_valid,
	output logic                   load_ready,
	input  pipe_pkg::load_pkt_t    load,
	input  logic                   start,
	output logic                   retire_valid,
	input  logic                   retire_ready,
	output pipe_pkg::retire_pkt_t  retire,
	output logic                   done
);

	logic load_fire;
	logic rd_en;
	pipe_pkg::imem_idx_t rd_index;
	isa_pkg::word_t rd_data;
	pipe_pkg::imem_count_t loaded_count;
	logic fetch_valid;
	logic fetch_ready;
	pipe_pkg::fetch_pkt_t fetch;
	logic fetching_done;
	isa_pkg::reg_idx_t rs_idx;
	isa_pkg::reg_idx_t rt_idx;
	isa_pkg::word_t rs_val;
	isa_pkg::word_t rt_val;
	logic dec_valid;
	logic dec_ready;
	pipe_pkg::decode_pkt_t dec;
	logic wr_en;
	isa_pkg::reg_idx_t wr_idx;
	isa_pkg::word_t wr_val;

	assign load_fire = load_valid && load_ready;
	assign done = fetching_done && !fetch_valid && !dec_valid && !retire_valid;  // Pipeline empty

	instr_memory u_imem (
		.clock(clock), .rst_n(rst_n), .load_valid(load_fire), .load(load),
		.rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
		.loaded_count(loaded_count)
	);

	fetch_stage u_fetch (
		.clock(clock), .rst_n(rst_n), .start(start), .loaded_count(loaded_count),
		.load_ready(load_ready), .rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
		.fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch(fetch),
		.fetching_done(fetching_done)
	);

	register_file u_regs (
		.clock(clock), .rst_n(rst_n), .rs_idx(rs_idx), .rt_idx(rt_idx),
		.rs_val(rs_val), .rt_val(rt_val), .wr_en(wr_en), .wr_idx(wr_idx), .wr_val(wr_val)
	);

	decode_stage u_decode (
		.clock(clock), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.fetch(fetch), .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_val(rs_val), .rt_val(rt_val),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec(dec)
	);

	execute_stage u_execute (
		.clock(clock), .rst_n(rst_n), .dec_valid(dec_valid), .dec_ready(dec_ready),
		.dec(dec), .retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire(retire), .wr_en(wr_en), .wr_idx(wr_idx), .wr_val(wr_val)
	);

endmodule

/* testbench/cpu_core_asserts.sv */
`timescale 1ns/100ps

module cpu_core_asserts (
	input logic                   clock,
	input logic                   rst_n,
	input logic                   load_ready,
	input logic                   start,
	input logic                   retire_valid,
	input logic                   retire_ready,
	input pipe_pkg::retire_pkt_t  retire,
	input logic                   done
);

	logic failed = 1'b0;  // Seen by the testbench

	function automatic void record_failure(input string msg);
		failed = 1'b1;
		$error("%s", msg);
	endfunction

	reset_values: assert property (@(posedge clock)
		!rst_n |-> !retire_valid && !done && load_ready)
		else record_failure("retire_valid, done or load_ready wrong during reset");

	// Stalled record must not change or vanish
	retire_hold: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire))
		else record_failure("retire record changed while the output was stalled");

	load_closed: assert property (@(posedge clock) disable iff (!rst_n)
		start && load_ready |=> !load_ready)
		else record_failure("load port still open after start");

	load_stays_closed: assert property (@(posedge clock) disable iff (!rst_n)
		!load_ready |=> !load_ready)
		else record_failure("load port reopened after start");

	done_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		done |=> done)
		else record_failure("done fell before reset");

endmodule

bind cpu_core cpu_core_asserts u_asserts (
	.clock(clock), .rst_n(rst_n), .load_ready(load_ready), .start(start),
	.retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire), .done(done)
);

/* testbench/cpu_core_tb.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_core_tb;

	localparam int TIMEOUT = 2000;

	logic clock;
	logic rst_n;
	logic load_valid;
	logic load_ready;
	pipe_pkg::load_pkt_t load;
	logic start;
	logic retire_valid;
	logic retire_ready;
	pipe_pkg::retire_pkt_t retire;
	logic done;

	integer seed;
	int retired;
	isa_pkg::word_t prog[$];
	pipe_pkg::retire_pkt_t exp_q[$];
	isa_pkg::word_t gold_regs [`CPU_REG_COUNT];

	// Kinds 0 to 15 pick a function code, 16 to 22 an I-type opcode
	logic [5:0] r_funcs [16] = '{isa_pkg::fn_sll, isa_pkg::fn_srl, isa_pkg::fn_sra,
		isa_pkg::fn_sllv, isa_pkg::fn_srlv, isa_pkg::fn_srav, isa_pkg::fn_add,
		isa_pkg::fn_addu, isa_pkg::fn_sub, isa_pkg::fn_subu, isa_pkg::fn_and,
		isa_pkg::fn_or, isa_pkg::fn_xor, isa_pkg::fn_nor, isa_pkg::fn_slt, isa_pkg::fn_sltu};
	logic [5:0] i_ops [7] = '{isa_pkg::op_addi, isa_pkg::op_addiu, isa_pkg::op_slti,
		isa_pkg::op_sltiu, isa_pkg::op_ori, isa_pkg::op_xori, isa_pkg::op_lui};

	cpu_core uut (
		.clock(clock), .rst_n(rst_n), .load_valid(load_valid), .load_ready(load_ready),
		.load(load), .start(start), .retire_valid(retire_valid),
		.retire_ready(retire_ready), .retire(retire), .done(done)
	);

	always #10 clock = ~clock;

	function automatic isa_pkg::word_t enc_r(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic isa_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Reference ISA semantics against the model register state
	function automatic pipe_pkg::retire_pkt_t predict(input isa_pkg::word_t pc,
			input isa_pkg::word_t ins);
		pipe_pkg::retire_pkt_t r;
		isa_pkg::word_t s;
		isa_pkg::word_t t;
		isa_pkg::word_t sx;
		logic [4:0] sa;
		s = gold_regs[ins[25:21]];
		t = gold_regs[ins[20:16]];
		sx = {{16{ins[15]}}, ins[15:0]};
		sa = ins[10:6];
		r = '{pc: pc, instr: ins, dest: ins[20:16], result: '0, wr: 1'b1};
		if (ins[31:26] == isa_pkg::op_rtype) begin
			r.dest = ins[15:11];
			case (ins[5:0])
				isa_pkg::fn_add, isa_pkg::fn_addu: r.result = s + t;
				isa_pkg::fn_sub, isa_pkg::fn_subu: r.result = s - t;
				isa_pkg::fn_and:  r.result = s & t;
				isa_pkg::fn_or:   r.result = s | t;
				isa_pkg::fn_xor:  r.result = s ^ t;
				isa_pkg::fn_nor:  r.result = ~(s | t);
				isa_pkg::fn_slt:  r.result = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
				isa_pkg::fn_sltu: r.result = (s < t) ? 32'd1 : 32'd0;
				isa_pkg::fn_sll:  r.result = t << sa;
				isa_pkg::fn_srl:  r.result = t >> sa;
				isa_pkg::fn_sra:  r.result = $signed(t) >>> sa;
				isa_pkg::fn_sllv: r.result = t << s[4:0];
				isa_pkg::fn_srlv: r.result = t >> s[4:0];
				isa_pkg::fn_srav: r.result = $signed(t) >>> s[4:0];
				default: r.wr = 1'b0;
			endcase
		end else begin
			case (ins[31:26])
				isa_pkg::op_addi, isa_pkg::op_addiu: r.result = s + sx;
				isa_pkg::op_slti:  r.result = ($signed(s) < $signed(sx)) ? 32'd1 : 32'd0;
				isa_pkg::op_sltiu: r.result = (s < sx) ? 32'd1 : 32'd0;
				isa_pkg::op_ori:   r.result = s | {16'h0000, ins[15:0]};
				isa_pkg::op_xori:  r.result = s ^ {16'h0000, ins[15:0]};
				isa_pkg::op_lui:   r.result = {ins[15:0], 16'h0000};
				default: r.wr = 1'b0;
			endcase
		end
		return r;
	endfunction

	// Registers 0 to 7 only, so dependencies come often
	task automatic emit_kind(input int kind);
		logic [31:0] rnd;
		rnd = $random(seed);
		if (kind < 16)
			prog.push_back(enc_r(r_funcs[kind], {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]},
				{2'b00, rnd[8:6]}, rnd[13:9]));
		else
			prog.push_back(enc_i(i_ops[kind - 16], {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]},
				rnd[31:16]));
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation aborted");
	endtask

	task automatic value_error(input string what, input isa_pkg::word_t expected,
			input isa_pkg::word_t actual);
		$display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
		$display("Test failed");
		$fatal(1, "retire record mismatch");
	endtask

	task automatic check_record(input int n, input pipe_pkg::retire_pkt_t exp);
		string name;
		name = $sformatf("retire_check #%0d", n);
		assert (retire.pc == exp.pc) else value_error({name, " pc"}, exp.pc, retire.pc);
		assert (retire.instr == exp.instr)
			else value_error({name, " instr"}, exp.instr, retire.instr);
		assert (retire.wr == exp.wr) else value_error({name, " wr"}, exp.wr, retire.wr);
		assert (retire.result == exp.result)
			else value_error({name, " result"}, exp.result, retire.result);
		if (exp.wr)
			assert (retire.dest == exp.dest)
				else value_error({name, " dest"}, exp.dest, retire.dest);
	endtask

	task automatic load_word(input int idx, input isa_pkg::word_t w);
		int waited;
		waited = 0;
		load_valid = 1'b1;
		load = '{index: pipe_pkg::imem_idx_t'(idx), instr: w};
		@(negedge clock);
		while (!load_ready) begin
			waited++;
			if (waited > TIMEOUT)
				abort_run("The load port never became ready");
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		load_valid = 1'b0;
	endtask

	// Sampled mid-cycle, so the next rising edge sees the same handshake
	always @(negedge clock) begin
		if (uut.u_asserts.failed) begin
			abort_run("A protocol assertion on the core ports failed");
		end else if (rst_n && retire_valid && retire_ready) begin
			if (retired >= exp_q.size()) begin
				abort_run("The core retired more instructions than were loaded");
			end else begin
				check_record(retired, exp_q[retired]);
				retired++;
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		pipe_pkg::retire_pkt_t r;
		int waited;
		seed = 57;
		clock = 1'b0;
		rst_n = 1'b1;
		load_valid = 1'b0;
		load = '0;
		start = 1'b0;
		retire_ready = 1'b1;
		retired = 0;
		for (int i = 0; i < `CPU_REG_COUNT; i++)
			gold_regs[i] = '0;

		// Seed r1 to r7 with LUI then ORI, each a dependent pair
		for (int n = 1; n < 8; n++) begin
			rnd = $random(seed);
			prog.push_back(enc_i(isa_pkg::op_lui, 5'd0, 5'(n), rnd[15:0]));
			prog.push_back(enc_i(isa_pkg::op_ori, 5'(n), 5'(n), rnd[31:16]));
		end
		for (int k = 0; k < 23; k++)
			emit_kind(k);
		prog.push_back(32'h0000_0000);  // NOP
		for (int k = 0; k < 11; k++) begin
			rnd = $random(seed);
			emit_kind(int'(rnd[7:0] % 23));
		end
		rnd = $random(seed);
		prog.push_back(enc_i(6'b111111, {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]}, rnd[31:16]));
		for (int k = 0; k < 11; k++) begin
			rnd = $random(seed);
			emit_kind(int'(rnd[7:0] % 23));
		end

		foreach (prog[i]) begin
			r = predict(`CPU_START_ADDR + 32'(i) * 32'd4, prog[i]);
			exp_q.push_back(r);
			if (r.wr && r.dest != 5'd0)
				gold_regs[r.dest] = r.result;
		end

		#2 rst_n = 1'b0;
		repeat (16) @(posedge clock);
		#1 rst_n = 1'b1;

		foreach (prog[i])
			load_word(i, prog[i]);
		start = 1'b1;
		@(posedge clock);
		#1 start = 1'b0;

		waited = 0;
		while (!done) begin
			@(posedge clock);
			#1;
			rnd = $random(seed);
			retire_ready = (rnd[1:0] != 2'b00);
			waited++;
			if (waited > TIMEOUT)
				abort_run("The core stalled before raising done");
		end

		// Done must hold while the pipeline sits empty
		repeat (3) @(posedge clock);
		#1;

		if (uut.u_asserts.failed) begin
			abort_run("A protocol assertion on the core ports failed");
		end else if (retired == exp_q.size()) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("[ERROR] retire_count: expected %0d, actual %0d", exp_q.size(), retired);
			$display("Test failed");
			$fatal(1, "retire count mismatch");
		end
	end

endmodule

/* project.f */
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_memory.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_core.sv
testbench/cpu_core_asserts.sv
testbench/cpu_core_tb.sv

/* Makefile */
SIM := obj_dir/Vcpu_core_tb
SOURCES := $(shell grep -v '^+' project.f) include/cpu_settings.svh

.PHONY: run clean

$(SIM): project.f $(SOURCES)
	verilator --binary --assert -Wno-fatal -f project.f --top-module cpu_core_tb -Mdir obj_dir

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test passed" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
